// File: hw/fetchPkg.sv
`default_nettype none

// Fetch addressing types and block geometry shared by the whole stage
package fetchPkg;

  localparam int unsigned PC_BITS     = 32;               // Byte address width
  localparam int unsigned SLOTS       = 4;                // Instructions per fetch block
  localparam int unsigned SLOT_BYTES  = 8;                // One instruction
  localparam int unsigned BLOCK_BYTES = SLOTS * SLOT_BYTES; // 32 byte aligned block

  // Offset widths inside a block
  localparam int unsigned SLOT_OFS_BITS  = $clog2(SLOT_BYTES);   // Byte offset in a slot
  localparam int unsigned BLOCK_OFS_BITS = $clog2(BLOCK_BYTES);  // Byte offset in a block
  localparam int unsigned SLOT_IDX_BITS  = $clog2(SLOTS);        // Slot number width

  typedef logic [PC_BITS-1:0] pc_t;             // Instruction byte address

  typedef logic [SLOT_IDX_BITS-1:0] slotIdx_t;  // Slot number in a block

  typedef logic [SLOTS-1:0] slotMask_t;         // One bit per slot

  typedef pc_t [SLOTS-1:0] slotPcArray_t;       // One address per slot

endpackage

`default_nettype wire

// File: hw/branchPkg.sv
`default_nettype none

// Branch descriptions used by the BTB banks and the next PC logic
package branchPkg;

  // Control transfer kinds, same encoding as the update bus of the core
  typedef enum logic [1:0] {
    RETURN = 2'b00,  // Target comes from the RAS
    CALL   = 2'b01,  // Pushes its fall-through address
    JUMP   = 2'b10,  // Always taken
    COND   = 2'b11   // Direction from the counter
  } ctrlType_t;

  typedef logic [1:0] counter_t;  // Saturating direction counter, MSB set means taken

  localparam counter_t CNT_STRONG_NT    = 2'd0;  // Lower saturation point
  localparam counter_t CNT_WEAK_TAKEN   = 2'd2;  // Value on allocation
  localparam counter_t CNT_STRONG_TAKEN = 2'd3;  // Upper saturation point

endpackage

`default_nettype wire

// File: hw/slotPredIf.sv
`timescale 1ns/1ps
`default_nettype none

// Lookup result of one BTB bank, combinational from the lookup PC
interface slotPredIf;

  logic                 hit;           // Valid entry with matching tag
  branchPkg::ctrlType_t ctrlType;      // Stored control type
  fetchPkg::pc_t        target;        // Stored target address
  logic                 counterTaken;  // Counter MSB, already gated by hit

  modport bank (
    output hit,
    output ctrlType,
    output target,
    output counterTaken
  );

  modport select (
    input hit,
    input ctrlType,
    input target,
    input counterTaken
  );

endinterface

`default_nettype wire

// File: hw/btbUpdateIf.sv
`timescale 1ns/1ps
`default_nettype none

// In-order training bus, one driver and one reader per bank
interface btbUpdateIf;

  logic                 en;        // Update strobe
  fetchPkg::slotMask_t  bankSel;   // One-hot target bank
  fetchPkg::pc_t        pc;        // Address of the control instruction
  fetchPkg::pc_t        target;    // Resolved target
  branchPkg::ctrlType_t ctrlType;  // Resolved control type
  logic                 taken;     // Resolved direction

  modport steer (
    output en, bankSel, pc, target, ctrlType, taken
  );

  modport bank (
    input en, bankSel, pc, target, ctrlType, taken
  );

endinterface

`default_nettype wire

// File: hw/fetchPcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchPcUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall_i,             // Back-pressure level
  input  logic                 recoverFlag_i,       // Commit side recovery
  input  fetchPkg::pc_t        recoverPC_i,
  input  logic                 exceptionFlag_i,
  input  fetchPkg::pc_t        exceptionPC_i,
  input  logic                 flagRecoverEX_i,     // EX redirect overrides the stall
  input  fetchPkg::pc_t        nextPc_i,            // From the next PC selector
  input  logic                 updateEn_i,
  input  fetchPkg::pc_t        updatePC_i,
  input  fetchPkg::pc_t        updateTargetAddr_i,
  input  branchPkg::ctrlType_t updateBrType_i,
  input  logic                 updateDir_i,
  btbUpdateIf.steer            upd,                 // Training bus to all banks
  output fetchPkg::pc_t        pc_o                 // Lookup PC
);

  fetchPkg::pc_t    pcReg;      // Program counter
  fetchPkg::slotIdx_t updSlot;  // Bank owning the update PC

  // Redirect priority, stall only blocks the sequential/predicted path
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (recoverFlag_i) begin
      pcReg <= recoverPC_i;
    end else if (exceptionFlag_i) begin
      pcReg <= exceptionPC_i;
    end else if (!stall_i || flagRecoverEX_i) begin
      pcReg <= nextPc_i;
    end
  end

  assign pc_o = pcReg;

  // Slot number sits just above the instruction byte offset (bits 4:3)
  assign updSlot = updatePC_i[fetchPkg::SLOT_OFS_BITS +: fetchPkg::SLOT_IDX_BITS];

  // Exactly one bank sees each update
  assign upd.bankSel  = fetchPkg::slotMask_t'(1) << updSlot;
  assign upd.en       = updateEn_i;        // Training ignores the stall
  assign upd.pc       = updatePC_i;
  assign upd.target   = updateTargetAddr_i;
  assign upd.ctrlType = updateBrType_i;
  assign upd.taken    = updateDir_i;

endmodule

`default_nettype wire

// File: hw/btbBank.sv
`timescale 1ns/1ps
`default_nettype none

module btbBank #(
  parameter int unsigned BTB_ENTRIES = 16,  // Power of two
  parameter int unsigned SLOT_ID     = 0    // Which bankSel bit belongs to this bank
) (
  input  logic          clk,
  input  logic          reset,
  input  fetchPkg::pc_t lookupPc_i,  // Fetch block address, offset bits ignored
  btbUpdateIf.bank      upd,
  slotPredIf.bank       res
);

  localparam int unsigned IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int unsigned TAG_LSB  = fetchPkg::BLOCK_OFS_BITS + IDX_BITS;
  localparam int unsigned TAG_BITS = fetchPkg::PC_BITS - TAG_LSB;

  typedef logic [IDX_BITS-1:0] btbIdx_t;  // Row in this bank
  typedef logic [TAG_BITS-1:0] btbTag_t;  // Remaining upper address bits

  logic [BTB_ENTRIES-1:0] valid;                 // Only state with a reset
  btbTag_t                tagArr  [BTB_ENTRIES];
  fetchPkg::pc_t          tgtArr  [BTB_ENTRIES];
  branchPkg::ctrlType_t   typeArr [BTB_ENTRIES];
  branchPkg::counter_t    cntArr  [BTB_ENTRIES];

  btbIdx_t             lkIdx;
  btbTag_t             lkTag;
  logic                lkHit;
  btbIdx_t             updIdx;
  btbTag_t             updTag;
  logic                updHit;
  logic                wrEn;       // Strobe aimed at this bank
  logic                isCond;
  logic                condStep;   // Counter training on an existing entry
  logic                allocate;   // Full entry write
  branchPkg::counter_t cntNext;

  // Lookup, reads the arrays as they stood before this cycle's write
  assign lkIdx = lookupPc_i[fetchPkg::BLOCK_OFS_BITS +: IDX_BITS];
  assign lkTag = lookupPc_i[TAG_LSB +: TAG_BITS];
  assign lkHit = valid[lkIdx] && (tagArr[lkIdx] == lkTag);

  assign res.hit          = lkHit;
  assign res.ctrlType     = typeArr[lkIdx];
  assign res.target       = tgtArr[lkIdx];
  assign res.counterTaken = lkHit & cntArr[lkIdx][1];  // MSB means taken

  // Update side decode
  assign wrEn   = upd.en & upd.bankSel[SLOT_ID];
  assign updIdx = upd.pc[fetchPkg::BLOCK_OFS_BITS +: IDX_BITS];
  assign updTag = upd.pc[TAG_LSB +: TAG_BITS];
  assign updHit = valid[updIdx] && (tagArr[updIdx] == updTag);
  assign isCond = (upd.ctrlType == branchPkg::COND);

  assign condStep = isCond & updHit;
  assign allocate = ~condStep & (~isCond | upd.taken);  // Not-taken miss leaves the table alone

  // One step toward the outcome, saturating at both ends
  always_comb begin
    cntNext = cntArr[updIdx];
    if (upd.taken && cntNext != branchPkg::CNT_STRONG_TAKEN) begin
      cntNext = cntNext + 1'b1;
    end else if (!upd.taken && cntNext != branchPkg::CNT_STRONG_NT) begin
      cntNext = cntNext - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;  // Every entry invalid
    end else if (wrEn && allocate) begin
      valid[updIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      if (condStep) begin
        cntArr[updIdx] <= cntNext;  // Hit keeps tag, target and type
      end else if (allocate) begin
        tagArr[updIdx]  <= updTag;
        tgtArr[updIdx]  <= upd.target;
        typeArr[updIdx] <= upd.ctrlType;
        cntArr[updIdx]  <= branchPkg::CNT_WEAK_TAKEN;  // Also for non-COND entries
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/nextPcSelect.sv
`timescale 1ns/1ps
`default_nettype none

module nextPcSelect (
  input  logic                   stall_i,
  input  fetchPkg::pc_t          pc_i,             // Current lookup PC
  input  logic                   flagRecoverEX_i,  // Highest priority redirect
  input  fetchPkg::pc_t          targetAddrEX_i,
  input  logic                   flagRecoverID_i,
  input  fetchPkg::pc_t          targetAddrID_i,
  slotPredIf.select              slot [fetchPkg::SLOTS],
  input  fetchPkg::pc_t          rasTop_i,
  output logic                   push_o,
  output fetchPkg::pc_t          pushAddr_o,
  output logic                   pop_o,
  output fetchPkg::pc_t          nextPc_o,
  output fetchPkg::slotMask_t    slotHit_o,
  output fetchPkg::slotMask_t    slotTaken_o,
  output fetchPkg::slotPcArray_t slotTarget_o
);

  fetchPkg::slotMask_t    hitV;
  fetchPkg::slotMask_t    takenV;
  branchPkg::ctrlType_t   typeV [fetchPkg::SLOTS];
  fetchPkg::slotPcArray_t predTgt;   // BTB target or RAS top per slot
  fetchPkg::slotPcArray_t retAddr;   // Fall-through address per slot
  fetchPkg::slotIdx_t     firstIdx;  // Lowest taken slot
  logic                   anyTaken;
  logic                   rasOk;     // RAS may move this cycle

  // Per-slot decode of the bank results
  for (genvar g = 0; g < fetchPkg::SLOTS; g++) begin : gSlot
    assign hitV[g]  = slot[g].hit;
    assign typeV[g] = slot[g].ctrlType;
    // Taken unless it is a COND predicted not taken
    assign takenV[g] = slot[g].hit &
                       ((slot[g].ctrlType != branchPkg::COND) | slot[g].counterTaken);
    assign predTgt[g] = (slot[g].ctrlType == branchPkg::RETURN) ? rasTop_i : slot[g].target;
    assign retAddr[g] = pc_i + fetchPkg::pc_t'(fetchPkg::SLOT_BYTES * (g + 1));
    assign slotTarget_o[g] = slot[g].hit ? predTgt[g] : '0;  // Zero on a miss
  end

  // First taken slot, lowest index wins
  always_comb begin
    anyTaken = 1'b0;
    firstIdx = '0;
    for (int i = fetchPkg::SLOTS - 1; i >= 0; i--) begin
      if (takenV[i]) begin
        anyTaken = 1'b1;
        firstIdx = fetchPkg::slotIdx_t'(i);
      end
    end
  end

  // Redirects first, then prediction, then the next block
  always_comb begin
    if (flagRecoverEX_i) begin
      nextPc_o = targetAddrEX_i;
    end else if (flagRecoverID_i) begin
      nextPc_o = targetAddrID_i;
    end else if (anyTaken) begin
      nextPc_o = predTgt[firstIdx];
    end else begin
      nextPc_o = pc_i + fetchPkg::pc_t'(fetchPkg::BLOCK_BYTES);
    end
  end

  // The prediction is thrown away on a stall or a redirect, so the RAS must not move
  assign rasOk = ~stall_i & ~flagRecoverID_i & ~flagRecoverEX_i;

  assign push_o     = rasOk & anyTaken & (typeV[firstIdx] == branchPkg::CALL);
  assign pop_o      = rasOk & anyTaken & (typeV[firstIdx] == branchPkg::RETURN);
  assign pushAddr_o = retAddr[firstIdx];  // Instruction after the call

  assign slotHit_o   = hitV;
  assign slotTaken_o = takenV;

endmodule

`default_nettype wire

// File: hw/returnStack.sv
`timescale 1ns/1ps
`default_nettype none

module returnStack #(
  parameter int unsigned RAS_DEPTH = 8  // Power of two so the pointer wraps
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          push_i,
  input  fetchPkg::pc_t pushAddr_i,
  input  logic          pop_i,
  output fetchPkg::pc_t top_o
);

  localparam int unsigned PTR_BITS = $clog2(RAS_DEPTH);

  typedef logic [PTR_BITS-1:0] rasPtr_t;

  fetchPkg::pc_t        stack [RAS_DEPTH];  // Return addresses
  logic [RAS_DEPTH-1:0] written;            // Entry holds a pushed address
  rasPtr_t              ptr;                // Top of stack
  rasPtr_t              ptrUp;

  assign ptrUp = ptr + 1'b1;  // Wraps, so overflow reuses the oldest slot

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr     <= '0;
      written <= '0;
    end else if (push_i) begin
      ptr            <= ptrUp;
      written[ptrUp] <= 1'b1;
    end else if (pop_i) begin
      ptr <= ptr - 1'b1;  // Underflow wraps too
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      stack[ptrUp] <= pushAddr_i;
    end
  end

  // Never written entry reads as zero
  assign top_o = written[ptr] ? stack[ptr] : '0;

endmodule

`default_nettype wire

// File: hw/fetchStage1.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage1 #(
  parameter int unsigned BTB_ENTRIES = 16,  // Per bank
  parameter int unsigned RAS_DEPTH   = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_i,
  input  logic                   recoverFlag_i,
  input  fetchPkg::pc_t          recoverPC_i,
  input  logic                   exceptionFlag_i,
  input  fetchPkg::pc_t          exceptionPC_i,
  input  logic                   flagRecoverID_i,
  input  fetchPkg::pc_t          targetAddrID_i,
  input  logic                   flagRecoverEX_i,
  input  fetchPkg::pc_t          targetAddrEX_i,
  input  fetchPkg::pc_t          updatePC_i,
  input  fetchPkg::pc_t          updateTargetAddr_i,
  input  branchPkg::ctrlType_t   updateBrType_i,
  input  logic                   updateDir_i,
  input  logic                   updateEn_i,
  output fetchPkg::pc_t          pc_o,
  output fetchPkg::slotMask_t    slotHit_o,
  output fetchPkg::slotMask_t    slotTaken_o,
  output fetchPkg::slotPcArray_t slotTarget_o
);

  fetchPkg::pc_t lookupPc;  // PC register, broadcast to banks
  fetchPkg::pc_t nextPc;
  fetchPkg::pc_t pushAddr;
  fetchPkg::pc_t rasTop;
  logic          push;
  logic          pop;

  btbUpdateIf updBus ();                       // Shared training bus
  slotPredIf  slotBus [fetchPkg::SLOTS] ();    // One per bank

  fetchPcUnit pcUnit (
    .clk                (clk),
    .reset              (reset),
    .stall_i            (stall_i),
    .recoverFlag_i      (recoverFlag_i),
    .recoverPC_i        (recoverPC_i),
    .exceptionFlag_i    (exceptionFlag_i),
    .exceptionPC_i      (exceptionPC_i),
    .flagRecoverEX_i    (flagRecoverEX_i),
    .nextPc_i           (nextPc),
    .updateEn_i         (updateEn_i),
    .updatePC_i         (updatePC_i),
    .updateTargetAddr_i (updateTargetAddr_i),
    .updateBrType_i     (updateBrType_i),
    .updateDir_i        (updateDir_i),
    .upd                (updBus),
    .pc_o               (lookupPc)
  );

  // One bank per slot position
  for (genvar g = 0; g < fetchPkg::SLOTS; g++) begin : gBank
    btbBank #(
      .BTB_ENTRIES (BTB_ENTRIES),
      .SLOT_ID     (g)
    ) bank (
      .clk        (clk),
      .reset      (reset),
      .lookupPc_i (lookupPc),
      .upd        (updBus),
      .res        (slotBus[g])
    );
  end

  nextPcSelect sel (
    .stall_i         (stall_i),
    .pc_i            (lookupPc),
    .flagRecoverEX_i (flagRecoverEX_i),
    .targetAddrEX_i  (targetAddrEX_i),
    .flagRecoverID_i (flagRecoverID_i),
    .targetAddrID_i  (targetAddrID_i),
    .slot            (slotBus),
    .rasTop_i        (rasTop),
    .push_o          (push),
    .pushAddr_o      (pushAddr),
    .pop_o           (pop),
    .nextPc_o        (nextPc),
    .slotHit_o       (slotHit_o),
    .slotTaken_o     (slotTaken_o),
    .slotTarget_o    (slotTarget_o)
  );

  returnStack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) ras (
    .clk        (clk),
    .reset      (reset),
    .push_i     (push),
    .pushAddr_i (pushAddr),
    .pop_i      (pop),
    .top_o      (rasTop)
  );

  assign pc_o = lookupPc;

endmodule

`default_nettype wire

// File: bench/fetchStage1Tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage1Tb;

  localparam int RESET_CYCLES = 4;
  localparam int LEN1 = 12;   // Sequential fetch
  localparam int LEN2 = 8;    // JUMP and slot priority
  localparam int LEN3 = 14;   // COND allocation and training
  localparam int LEN4 = 14;   // Nested CALL and RETURN
  localparam int LEN5 = 60;   // Random redirect strobes
  localparam int LEN6 = 300;  // Random mix
  localparam int MAX_CYCLES = (RESET_CYCLES + LEN1 + LEN2 + LEN3 + LEN4 + LEN5 + LEN6 + 6) * 3 / 2;

  logic                   clk;
  logic                   reset;
  logic                   stall;
  logic                   recoverFlag;
  fetchPkg::pc_t          recoverPc;
  logic                   exceptionFlag;
  fetchPkg::pc_t          exceptionPc;
  logic                   flagRecoverId;
  fetchPkg::pc_t          targetAddrId;
  logic                   flagRecoverEx;
  fetchPkg::pc_t          targetAddrEx;
  fetchPkg::pc_t          updatePc;
  fetchPkg::pc_t          updateTarget;
  branchPkg::ctrlType_t   updateType;
  logic                   updateDir;
  logic                   updateEn;
  fetchPkg::pc_t          pc;
  fetchPkg::slotMask_t    slotHit;
  fetchPkg::slotMask_t    slotTaken;
  fetchPkg::slotPcArray_t slotTarget;

  // Reference state, 4 banks of 16 entries, 8 deep RAS
  logic                   mValid   [4][16];
  logic [22:0]            mTag     [4][16];  // PC bits 31:9
  fetchPkg::pc_t          mTgt     [4][16];
  logic [1:0]             mType    [4][16];
  logic [1:0]             mCnt     [4][16];
  fetchPkg::pc_t          mStack   [8];
  logic                   mWritten [8];
  logic [2:0]             mPtr;
  fetchPkg::pc_t          mPc;

  fetchPkg::slotMask_t    eHit;    // Expected outputs of the current cycle
  fetchPkg::slotMask_t    eTaken;
  fetchPkg::slotPcArray_t eTgt;
  int                     eFirst;  // First taken slot, -1 if none

  integer seed = 32'he952_61f1;
  int     errCount = 0;
  int     checkCount = 0;
  int     cycleCount = 0;

  fetchStage1 #(
    .BTB_ENTRIES (16),
    .RAS_DEPTH   (8)
  ) dut_i (
    .clk                (clk),
    .reset              (reset),
    .stall_i            (stall),
    .recoverFlag_i      (recoverFlag),
    .recoverPC_i        (recoverPc),
    .exceptionFlag_i    (exceptionFlag),
    .exceptionPC_i      (exceptionPc),
    .flagRecoverID_i    (flagRecoverId),
    .targetAddrID_i     (targetAddrId),
    .flagRecoverEX_i    (flagRecoverEx),
    .targetAddrEX_i     (targetAddrEx),
    .updatePC_i         (updatePc),
    .updateTargetAddr_i (updateTarget),
    .updateBrType_i     (updateType),
    .updateDir_i        (updateDir),
    .updateEn_i         (updateEn),
    .pc_o               (pc),
    .slotHit_o          (slotHit),
    .slotTaken_o        (slotTaken),
    .slotTarget_o       (slotTarget)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic fetchPkg::pc_t rasTop();
    rasTop = mWritten[mPtr] ? mStack[mPtr] : 32'h0;  // Unwritten entry reads 0
  endfunction

  // Expected lookup of all four slots for one block address
  function automatic void predictBlock(input fetchPkg::pc_t blockPc,
                                       output fetchPkg::slotMask_t hit,
                                       output fetchPkg::slotMask_t taken,
                                       output fetchPkg::slotPcArray_t tgt,
                                       output int first);
    logic [3:0]  idx;
    logic [22:0] tg;
    idx   = blockPc[8:5];
    tg    = blockPc[31:9];
    first = -1;
    for (int s = 0; s < 4; s++) begin
      hit[s]   = mValid[s][idx] && (mTag[s][idx] == tg);
      taken[s] = hit[s] && ((mType[s][idx] != branchPkg::COND) || mCnt[s][idx][1]);
      if (!hit[s]) tgt[s] = 32'h0;
      else if (mType[s][idx] == branchPkg::RETURN) tgt[s] = rasTop();
      else tgt[s] = mTgt[s][idx];
      if (taken[s] && first < 0) first = s;  // Lowest slot wins
    end
  endfunction

  task automatic resetModel();
    for (int b = 0; b < 4; b++) begin
      for (int e = 0; e < 16; e++) mValid[b][e] = 1'b0;
    end
    for (int e = 0; e < 8; e++) mWritten[e] = 1'b0;
    mPtr = 3'd0;
    mPc  = 32'h0;
  endtask

  // State after the coming clock edge, from this cycle's inputs
  task automatic advanceModel();
    fetchPkg::pc_t nxt;
    logic [3:0]    idx;
    logic [22:0]   tg;
    int            bank;
    logic          hitU;
    logic          rasMove;
    idx = mPc[8:5];
    nxt = (eFirst >= 0) ? eTgt[eFirst] : mPc + 32'd32;
    if (flagRecoverEx) nxt = targetAddrEx;
    else if (flagRecoverId) nxt = targetAddrId;
    rasMove = !stall && !flagRecoverId && !flagRecoverEx && (eFirst >= 0);
    if (rasMove && mType[eFirst][idx] == branchPkg::CALL) begin
      mPtr = mPtr + 3'd1;
      mStack[mPtr]   = mPc + fetchPkg::pc_t'(8 * (eFirst + 1));  // Return after the call
      mWritten[mPtr] = 1'b1;
    end else if (rasMove && mType[eFirst][idx] == branchPkg::RETURN) begin
      mPtr = mPtr - 3'd1;
    end
    if (recoverFlag) mPc = recoverPc;
    else if (exceptionFlag) mPc = exceptionPc;
    else if (!stall || flagRecoverEx) mPc = nxt;  // Stall holds unless EX redirect
    if (updateEn) begin
      bank = int'(updatePc[4:3]);
      idx  = updatePc[8:5];
      tg   = updatePc[31:9];
      hitU = mValid[bank][idx] && (mTag[bank][idx] == tg);
      if (updateType == branchPkg::COND && hitU) begin
        if (updateDir && mCnt[bank][idx] != 2'd3) mCnt[bank][idx] = mCnt[bank][idx] + 2'd1;
        else if (!updateDir && mCnt[bank][idx] != 2'd0) mCnt[bank][idx] = mCnt[bank][idx] - 2'd1;
      end else if (updateType != branchPkg::COND || updateDir) begin
        mValid[bank][idx] = 1'b1;
        mTag[bank][idx]   = tg;
        mTgt[bank][idx]   = updateTarget;
        mType[bank][idx]  = updateType;
        mCnt[bank][idx]   = 2'd2;  // Weakly taken on allocation
      end
    end
  endtask

  // Compare every cycle where outputs have settled
  always @(negedge clk) begin
    if (reset) begin
      resetModel();
    end else begin
      predictBlock(mPc, eHit, eTaken, eTgt, eFirst);
      checkValue("pc_o", pc, mPc);
      checkValue("slotHit_o", {28'h0, slotHit}, {28'h0, eHit});
      checkValue("slotTaken_o", {28'h0, slotTaken}, {28'h0, eTaken});
      for (int s = 0; s < 4; s++) begin
        checkValue($sformatf("slotTarget_o[%0d]", s), slotTarget[s], eTgt[s]);
      end
      advanceModel();
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic clearStrobes();
    stall         <= 1'b0;
    recoverFlag   <= 1'b0;
    exceptionFlag <= 1'b0;
    flagRecoverId <= 1'b0;
    flagRecoverEx <= 1'b0;
    updateEn      <= 1'b0;
  endtask

  task automatic trainCycle(input fetchPkg::pc_t at, input fetchPkg::pc_t tgt,
                            input branchPkg::ctrlType_t kind, input logic dir);
    @(posedge clk);
    clearStrobes();
    updateEn     <= 1'b1;
    updatePc     <= at;
    updateTarget <= tgt;
    updateType   <= kind;
    updateDir    <= dir;
  endtask

  task automatic redirectCycle(input fetchPkg::pc_t to);
    @(posedge clk);
    clearStrobes();
    recoverFlag <= 1'b1;
    recoverPc   <= to;
  endtask

  // One idle cycle, then the PC it must have reached
  task automatic expectPc(input fetchPkg::pc_t want);
    @(posedge clk);
    clearStrobes();
    @(negedge clk);
    checkValue("pc_o", pc, want);
  endtask

  function automatic fetchPkg::pc_t randomPc();
    randomPc = $random(seed) & 32'h0000_07f8;  // Slot aligned, small window for hits
  endfunction

  task automatic finishTest(input string name, input int errBefore);
    @(posedge clk);
    clearStrobes();
    @(negedge clk);
    #1;
    $display("test %s: %0d mismatches", name, errCount - errBefore);
  endtask

  task automatic randomCycles(input int n, input logic withUpdates);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      clearStrobes();
      r = $random(seed);
      recoverFlag   <= withUpdates ? (r[19:17] == 3'd0) : (r[2:0] == 3'd0);
      exceptionFlag <= withUpdates ? (r[24:22] == 3'd0) : (r[5:3] == 3'd0);
      flagRecoverEx <= withUpdates ? (r[27:25] == 3'd0) : (r[7:6] == 2'd0);
      flagRecoverId <= withUpdates ? (r[30:28] == 3'd0) : (r[9:8] == 2'd0);
      stall         <= withUpdates ? (r[21:20] == 2'd0) : r[10];
      recoverPc     <= randomPc();
      exceptionPc   <= randomPc();
      targetAddrEx  <= randomPc();
      targetAddrId  <= randomPc();
      if (withUpdates) begin
        updateEn     <= r[12] | r[13];  // Three updates in four cycles
        updatePc     <= randomPc();
        updateTarget <= randomPc();
        updateType   <= branchPkg::ctrlType_t'(r[15:14]);
        updateDir    <= r[16];
      end
    end
  endtask

  initial begin
    int errBefore;
    reset = 1'b1;
    stall = 1'b0;
    recoverFlag = 1'b0;
    recoverPc = 32'h0;
    exceptionFlag = 1'b0;
    exceptionPc = 32'h0;
    flagRecoverId = 1'b0;
    targetAddrId = 32'h0;
    flagRecoverEx = 1'b0;
    targetAddrEx = 32'h0;
    updatePc = 32'h0;
    updateTarget = 32'h0;
    updateType = branchPkg::RETURN;
    updateDir = 1'b0;
    updateEn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    errBefore = errCount;
    for (int i = 0; i < LEN1; i++) begin
      expectPc(fetchPkg::pc_t'(32 * (i + 1)));  // Plain block stepping
      checkValue("slotHit_o", {28'h0, slotHit}, 32'h0);
    end
    finishTest("sequential fetch", errBefore);

    errBefore = errCount;
    trainCycle(32'h158, 32'h900, branchPkg::JUMP, 1'b1);  // Slot 3
    trainCycle(32'h148, 32'h800, branchPkg::JUMP, 1'b1);  // Slot 1 of the same block
    redirectCycle(32'h140);
    expectPc(32'h140);
    checkValue("slotTaken_o", {28'h0, slotTaken}, 32'ha);
    expectPc(32'h800);  // Earlier slot wins
    finishTest("jump and slot priority", errBefore);

    errBefore = errCount;
    trainCycle(32'h1d0, 32'ha00, branchPkg::COND, 1'b0);  // Not-taken miss, no allocation
    redirectCycle(32'h1c0);
    expectPc(32'h1c0);
    checkValue("slotHit_o", {28'h0, slotHit}, 32'h0);
    trainCycle(32'h1d0, 32'ha00, branchPkg::COND, 1'b1);
    redirectCycle(32'h1c0);
    expectPc(32'h1c0);
    checkValue("slotTaken_o", {28'h0, slotTaken}, 32'h4);
    expectPc(32'ha00);
    trainCycle(32'h1d0, 32'ha00, branchPkg::COND, 1'b0);
    trainCycle(32'h1d0, 32'ha00, branchPkg::COND, 1'b0);
    redirectCycle(32'h1c0);
    expectPc(32'h1c0);
    checkValue("slotHit_o", {28'h0, slotHit}, 32'h4);
    checkValue("slotTaken_o", {28'h0, slotTaken}, 32'h0);
    expectPc(32'h1e0);  // Falls through
    finishTest("cond training", errBefore);

    errBefore = errCount;
    trainCycle(32'h278, 32'h600, branchPkg::CALL, 1'b1);    // Pushes 0x280
    trainCycle(32'h618, 32'h700, branchPkg::CALL, 1'b1);    // Pushes 0x620
    trainCycle(32'h708, 32'h0, branchPkg::RETURN, 1'b1);
    trainCycle(32'h620, 32'h0, branchPkg::RETURN, 1'b1);
    redirectCycle(32'h260);
    expectPc(32'h260);
    expectPc(32'h600);
    expectPc(32'h700);
    checkValue("slotTarget_o[1]", slotTarget[1], 32'h620);  // RAS top shown for a RETURN
    expectPc(32'h620);
    expectPc(32'h280);  // Inner return first, then outer
    finishTest("call and return", errBefore);

    errBefore = errCount;
    randomCycles(LEN5, 1'b0);
    finishTest("redirect priority", errBefore);

    errBefore = errCount;
    randomCycles(LEN6, 1'b1);
    finishTest("random mix", errBefore);

    $display("checks %0d, mismatches %0d, cycles %0d", checkCount, errCount, cycleCount);
    if (errCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/fetchPkg.sv
hw/branchPkg.sv
hw/slotPredIf.sv
hw/btbUpdateIf.sv
hw/fetchPcUnit.sv
hw/btbBank.sv
hw/nextPcSelect.sv
hw/returnStack.sv
hw/fetchStage1.sv
bench/fetchStage1Tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=fetchStage1Tb
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" --Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
